/* source/m72_pkg.sv */
package m72_pkg;

	// game memory geometry
	localparam int MEM_AW = 12;
	localparam int MEM_WORDS = 1 << MEM_AW;

	// cycles from mem_start to mem_done
	localparam int MEM_LATENCY = 4;

	// core reset hold after the download ends
	localparam int RESET_HOLD = 64;

	// leading download bytes that form the board config
	localparam int CFG_BYTES = 2;

	typedef logic [MEM_AW-1:0] mem_addr_t;
	typedef logic [15:0] mem_data_t;
	typedef logic [7:0] byte_t;

	// bit 0 enables the low byte
	typedef logic [1:0] be_t;

	typedef logic [$clog2(MEM_LATENCY)-1:0] lat_cnt_t;
	typedef logic [$clog2(RESET_HOLD)-1:0] hold_cnt_t;
	typedef logic [$clog2(CFG_BYTES+1)-1:0] cfg_cnt_t;

	typedef struct packed {
		byte_t board_id;
		byte_t board_flags;
	} board_cfg_t;

	// one access from the arbiter to the memory
	typedef struct packed {
		mem_addr_t addr;
		mem_data_t wdata;
		be_t be;
		logic we;
	} mem_req_t;

	typedef enum logic {
		ARB_IDLE,
		ARB_BUSY
	} arb_state_t;

endpackage

/* source/rom_loader.sv */
module rom_loader (
	input logic CLK_32M,
	input logic arst_n,
	input logic ioctl_downl,
	input logic ioctl_wr,
	input m72_pkg::byte_t ioctl_dout,
	output logic ioctl_wait,
	output logic ld_req,
	input logic ld_ack,
	output m72_pkg::mem_addr_t ld_addr,
	output m72_pkg::mem_data_t ld_data,
	output m72_pkg::be_t ld_be,
	output m72_pkg::board_cfg_t board_cfg
);

	logic downl_d;
	m72_pkg::cfg_cnt_t cfg_cnt;
	logic have_lo;
	logic dl_end;
	logic cfg_done;
	logic take_cfg;
	logic take_lo;
	logic take_hi;
	logic flush;

	assign dl_end = downl_d && !ioctl_downl;
	assign cfg_done = cfg_cnt == m72_pkg::cfg_cnt_t'(m72_pkg::CFG_BYTES);
	assign take_cfg = ioctl_downl && ioctl_wr && !cfg_done;
	assign take_lo = ioctl_downl && ioctl_wr && cfg_done && !have_lo;
	assign take_hi = ioctl_downl && ioctl_wr && cfg_done && have_lo;
	// half-filled word left at the end of the download
	assign flush = dl_end && have_lo;

	always_ff @(posedge CLK_32M or negedge arst_n) begin
		if (!arst_n) begin
			downl_d <= 1'b0;
			cfg_cnt <= '0;
			have_lo <= 1'b0;
			ioctl_wait <= 1'b0;
			ld_req <= 1'b0;
			ld_addr <= '0;
			board_cfg <= '0;
		end else begin
			downl_d <= ioctl_downl;

			// word accepted, move on
			if (ioctl_wait && ld_req == ld_ack) begin
				ioctl_wait <= 1'b0;
				ld_addr <= ld_addr + m72_pkg::mem_addr_t'(1);
			end

			if (take_cfg) begin
				cfg_cnt <= cfg_cnt + m72_pkg::cfg_cnt_t'(1);
				if (cfg_cnt == '0) begin
					board_cfg.board_id <= ioctl_dout;
					ld_addr <= '0;
				end else begin
					board_cfg.board_flags <= ioctl_dout;
				end
			end

			if (take_lo)
				have_lo <= 1'b1;

			if (take_hi || flush) begin
				have_lo <= 1'b0;
				ld_req <= ~ld_req;
				ioctl_wait <= 1'b1;
			end

			if (dl_end)
				cfg_cnt <= '0;
		end
	end

	always_ff @(posedge CLK_32M) begin
		if (take_lo)
			ld_data[7:0] <= ioctl_dout;
		if (take_hi) begin
			ld_data[15:8] <= ioctl_dout;
			ld_be <= 2'b11;
		end
		if (flush)
			ld_be <= 2'b01;
	end

	// download source must hold off while a word is in flight
	a_wr_during_wait: assert property (@(posedge CLK_32M) disable iff (!arst_n)
		ioctl_wait |-> !ioctl_wr)
		else $error("ioctl_wr strobed while ioctl_wait is high");

endmodule

/* source/reset_gen.sv */
module reset_gen (
	input logic CLK_32M,
	input logic arst_n,
	input logic ioctl_downl,
	output logic rom_loaded,
	output logic core_reset_n
);

	logic downl_d;
	m72_pkg::hold_cnt_t hold_cnt;

	always_ff @(posedge CLK_32M or negedge arst_n) begin
		if (!arst_n) begin
			downl_d <= 1'b0;
			hold_cnt <= '0;
			rom_loaded <= 1'b0;
			core_reset_n <= 1'b0;
		end else begin
			downl_d <= ioctl_downl;
			if (ioctl_downl) begin
				// new download puts the core back in reset
				rom_loaded <= 1'b0;
				core_reset_n <= 1'b0;
			end else if (downl_d) begin
				rom_loaded <= 1'b1;
				// count to zero plus the output register makes RESET_HOLD cycles
				hold_cnt <= m72_pkg::hold_cnt_t'(m72_pkg::RESET_HOLD - 2);
			end else if (rom_loaded) begin
				if (hold_cnt != '0)
					hold_cnt <= hold_cnt - m72_pkg::hold_cnt_t'(1);
				else
					core_reset_n <= 1'b1;
			end
		end
	end

endmodule

/* source/mem_arbiter.sv */
module mem_arbiter (
	input logic CLK_32M,
	input logic arst_n,
	input logic ld_req,
	input m72_pkg::mem_addr_t ld_addr,
	input m72_pkg::mem_data_t ld_data,
	input m72_pkg::be_t ld_be,
	output logic ld_ack,
	input logic cpu_req,
	input m72_pkg::mem_addr_t cpu_addr,
	input logic cpu_we,
	input m72_pkg::be_t cpu_ds,
	input m72_pkg::mem_data_t cpu_d,
	output logic cpu_ack,
	output m72_pkg::mem_data_t cpu_q,
	input logic gfx_req,
	input m72_pkg::mem_addr_t gfx_addr,
	output logic gfx_ack,
	output m72_pkg::mem_data_t gfx_q,
	output logic mem_start,
	output m72_pkg::mem_req_t mem_req,
	input logic mem_done,
	input m72_pkg::mem_data_t mem_rdata
);

	m72_pkg::arb_state_t state;
	logic ld_pend;
	logic cpu_pend;
	logic gfx_pend;
	// one-hot {gfx, cpu, loader}
	logic [2:0] sel;
	logic [2:0] gnt;

	assign ld_pend = ld_req != ld_ack;
	assign cpu_pend = cpu_req != cpu_ack;
	assign gfx_pend = gfx_req != gfx_ack;

	// loader first, then cpu, then gfx
	always_comb begin
		sel = 3'b000;
		if (ld_pend)
			sel = 3'b001;
		else if (cpu_pend)
			sel = 3'b010;
		else if (gfx_pend)
			sel = 3'b100;
	end

	always_ff @(posedge CLK_32M or negedge arst_n) begin
		if (!arst_n) begin
			state <= m72_pkg::ARB_IDLE;
			gnt <= 3'b000;
			mem_start <= 1'b0;
			ld_ack <= 1'b0;
			cpu_ack <= 1'b0;
			gfx_ack <= 1'b0;
		end else begin
			mem_start <= 1'b0;
			case (state)
				m72_pkg::ARB_IDLE: begin
					if (sel != 3'b000) begin
						gnt <= sel;
						mem_start <= 1'b1;
						state <= m72_pkg::ARB_BUSY;
					end
				end
				m72_pkg::ARB_BUSY: begin
					if (mem_done) begin
						if (gnt[0])
							ld_ack <= ~ld_ack;
						if (gnt[1])
							cpu_ack <= ~cpu_ack;
						if (gnt[2])
							gfx_ack <= ~gfx_ack;
						state <= m72_pkg::ARB_IDLE;
					end
				end
				default: state <= m72_pkg::ARB_IDLE;
			endcase
		end
	end

	always_ff @(posedge CLK_32M) begin
		if (state == m72_pkg::ARB_IDLE) begin
			if (ld_pend)
				mem_req <= '{addr: ld_addr, wdata: ld_data, be: ld_be, we: 1'b1};
			else if (cpu_pend)
				mem_req <= '{addr: cpu_addr, wdata: cpu_d, be: cpu_ds, we: cpu_we};
			else
				mem_req <= '{addr: gfx_addr, wdata: '0, be: 2'b11, we: 1'b0};
		end
		if (state == m72_pkg::ARB_BUSY && mem_done) begin
			if (gnt[1])
				cpu_q <= mem_rdata;
			if (gnt[2])
				gfx_q <= mem_rdata;
		end
	end

	a_done_when_busy: assert property (@(posedge CLK_32M) disable iff (!arst_n)
		mem_done |-> state == m72_pkg::ARB_BUSY)
		else $error("mem_done without an access in flight");

	a_start_from_idle: assert property (@(posedge CLK_32M) disable iff (!arst_n)
		mem_start |-> $past(state == m72_pkg::ARB_IDLE))
		else $error("mem_start not issued from idle");

endmodule

/* source/mem_ctrl.sv */
module mem_ctrl (
	input logic CLK_32M,
	input logic arst_n,
	input logic mem_start,
	input m72_pkg::mem_req_t mem_req,
	output logic mem_done,
	output m72_pkg::mem_data_t mem_rdata
);

	m72_pkg::mem_data_t mem [m72_pkg::MEM_WORDS];
	m72_pkg::mem_addr_t addr_q;
	// nonzero while an access is in flight
	m72_pkg::lat_cnt_t lat_cnt;

	always_ff @(posedge CLK_32M or negedge arst_n) begin
		if (!arst_n) begin
			lat_cnt <= '0;
			mem_done <= 1'b0;
		end else begin
			mem_done <= 1'b0;
			if (mem_start) begin
				lat_cnt <= m72_pkg::lat_cnt_t'(m72_pkg::MEM_LATENCY - 1);
			end else if (lat_cnt != '0) begin
				lat_cnt <= lat_cnt - m72_pkg::lat_cnt_t'(1);
				if (lat_cnt == m72_pkg::lat_cnt_t'(1))
					mem_done <= 1'b1;
			end
		end
	end

	// write lands at start, read-back at the end sees it
	always_ff @(posedge CLK_32M) begin
		if (mem_start) begin
			addr_q <= mem_req.addr;
			if (mem_req.we && mem_req.be[0])
				mem[mem_req.addr][7:0] <= mem_req.wdata[7:0];
			if (mem_req.we && mem_req.be[1])
				mem[mem_req.addr][15:8] <= mem_req.wdata[15:8];
		end
		if (lat_cnt == m72_pkg::lat_cnt_t'(1))
			mem_rdata <= mem[addr_q];
	end

	a_single_access: assert property (@(posedge CLK_32M) disable iff (!arst_n)
		mem_start |-> lat_cnt == '0)
		else $error("mem_start while an access is in flight");

endmodule

/* source/m72_mem_top.sv */
module m72_mem_top (
	input logic CLK_32M,
	input logic arst_n,
	input logic ioctl_downl,
	input logic ioctl_wr,
	input m72_pkg::byte_t ioctl_dout,
	output logic ioctl_wait,
	input logic cpu_req,
	input m72_pkg::mem_addr_t cpu_addr,
	input logic cpu_we,
	input m72_pkg::be_t cpu_ds,
	input m72_pkg::mem_data_t cpu_d,
	output logic cpu_ack,
	output m72_pkg::mem_data_t cpu_q,
	input logic gfx_req,
	input m72_pkg::mem_addr_t gfx_addr,
	output logic gfx_ack,
	output m72_pkg::mem_data_t gfx_q,
	output m72_pkg::board_cfg_t board_cfg,
	output logic rom_loaded,
	output logic core_reset_n
);

	logic ld_req;
	logic ld_ack;
	m72_pkg::mem_addr_t ld_addr;
	m72_pkg::mem_data_t ld_data;
	m72_pkg::be_t ld_be;
	logic mem_start;
	m72_pkg::mem_req_t mem_req;
	logic mem_done;
	m72_pkg::mem_data_t mem_rdata;

	rom_loader rom_loader_i (
		.CLK_32M (CLK_32M),
		.arst_n (arst_n),
		.ioctl_downl (ioctl_downl),
		.ioctl_wr (ioctl_wr),
		.ioctl_dout (ioctl_dout),
		.ioctl_wait (ioctl_wait),
		.ld_req (ld_req),
		.ld_ack (ld_ack),
		.ld_addr (ld_addr),
		.ld_data (ld_data),
		.ld_be (ld_be),
		.board_cfg (board_cfg)
	);

	reset_gen reset_gen_i (
		.CLK_32M (CLK_32M),
		.arst_n (arst_n),
		.ioctl_downl (ioctl_downl),
		.rom_loaded (rom_loaded),
		.core_reset_n (core_reset_n)
	);

	mem_arbiter mem_arbiter_i (
		.CLK_32M (CLK_32M),
		.arst_n (arst_n),
		.ld_req (ld_req),
		.ld_addr (ld_addr),
		.ld_data (ld_data),
		.ld_be (ld_be),
		.ld_ack (ld_ack),
		.cpu_req (cpu_req),
		.cpu_addr (cpu_addr),
		.cpu_we (cpu_we),
		.cpu_ds (cpu_ds),
		.cpu_d (cpu_d),
		.cpu_ack (cpu_ack),
		.cpu_q (cpu_q),
		.gfx_req (gfx_req),
		.gfx_addr (gfx_addr),
		.gfx_ack (gfx_ack),
		.gfx_q (gfx_q),
		.mem_start (mem_start),
		.mem_req (mem_req),
		.mem_done (mem_done),
		.mem_rdata (mem_rdata)
	);

	mem_ctrl mem_ctrl_i (
		.CLK_32M (CLK_32M),
		.arst_n (arst_n),
		.mem_start (mem_start),
		.mem_req (mem_req),
		.mem_done (mem_done),
		.mem_rdata (mem_rdata)
	);

endmodule

/* verification/m72_mem_tb.sv */
module m72_mem_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int ACK_LIMIT = 40;
	localparam int ISO_LAT = m72_pkg::MEM_LATENCY + 2;
	localparam int WR_TESTS = 24;
	localparam int STREAM_LEN = 20;

	logic CLK_32M = 1'b0;
	logic arst_n;
	logic ioctl_downl;
	logic ioctl_wr;
	m72_pkg::byte_t ioctl_dout;
	logic ioctl_wait;
	logic cpu_req;
	m72_pkg::mem_addr_t cpu_addr;
	logic cpu_we;
	m72_pkg::be_t cpu_ds;
	m72_pkg::mem_data_t cpu_d;
	logic cpu_ack;
	m72_pkg::mem_data_t cpu_q;
	logic gfx_req;
	m72_pkg::mem_addr_t gfx_addr;
	logic gfx_ack;
	m72_pkg::mem_data_t gfx_q;
	m72_pkg::board_cfg_t board_cfg;
	logic rom_loaded;
	logic core_reset_n;

	m72_pkg::mem_data_t model [m72_pkg::MEM_WORDS];
	m72_pkg::board_cfg_t model_cfg;
	logic [31:0] rng_state;
	int cycles = 0;
	int cycle_limit = 1000000;
	int n_words;
	int n_bytes;

	m72_mem_top m72_mem_top_i (.*);

	always #5 CLK_32M = ~CLK_32M;

	always @(posedge CLK_32M) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit)
			abort_run($sformatf("timeout: run did not finish within %0d cycles", cycle_limit));
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Checks failed");
		$fatal(1, "stopping at the first failure");
	endtask

	// upper half of each lcg step
	function automatic logic [15:0] rand_next();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state[31:16];
	endfunction

	function automatic void apply_write(m72_pkg::mem_addr_t a, m72_pkg::mem_data_t d,
		m72_pkg::be_t be);
		if (be[0])
			model[a][7:0] = d[7:0];
		if (be[1])
			model[a][15:8] = d[15:8];
	endfunction

	task automatic check_word(input m72_pkg::mem_data_t got, input m72_pkg::mem_data_t exp,
		input string what);
		if (got !== exp)
			abort_run($sformatf("[ERROR] %0t: %s got %h expected %h", $time, what, got, exp));
	endtask

	task automatic check_cfg(input m72_pkg::board_cfg_t got, input m72_pkg::board_cfg_t exp,
		input string what);
		if (got !== exp)
			abort_run($sformatf("[ERROR] %0t: %s got id %h flags %h expected id %h flags %h",
				$time, what, got.board_id, got.board_flags, exp.board_id, exp.board_flags));
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		if (got !== exp)
			abort_run($sformatf("[ERROR] %0t: %s got %b expected %b", $time, what, got, exp));
	endtask

	task automatic check_count(input int got, input int exp, input string what);
		if (got != exp)
			abort_run($sformatf("[ERROR] %0t: %s got %0d expected %0d", $time, what, got, exp));
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge CLK_32M);
			#1;
		end
	endtask

	task automatic send_byte(input m72_pkg::byte_t b);
		int n;
		n = 0;
		while (ioctl_wait) begin
			idle_cycles(1);
			n++;
			if (n > ACK_LIMIT)
				abort_run("ioctl_wait stayed high, the loader never finished a word");
		end
		@(posedge CLK_32M);
		ioctl_wr <= 1'b1;
		ioctl_dout <= b;
		@(posedge CLK_32M);
		ioctl_wr <= 1'b0;
		#1;
	endtask

	// one cpu access; reads are checked against the model at the ack
	task automatic cpu_access(input logic we, input m72_pkg::mem_addr_t a,
		input m72_pkg::be_t ds, input m72_pkg::mem_data_t d, output int lat);
		@(posedge CLK_32M);
		cpu_addr <= a;
		cpu_we <= we;
		cpu_ds <= ds;
		cpu_d <= d;
		cpu_req <= ~cpu_req;
		lat = 0;
		do begin
			@(posedge CLK_32M);
			#1;
			lat++;
			if (lat > ACK_LIMIT)
				abort_run("cpu_ack never toggled after a cpu request");
		end while (cpu_ack !== cpu_req);
		if (we)
			apply_write(a, d, ds);
		else
			check_word(cpu_q, model[a], "cpu read data");
	endtask

	task automatic gfx_access(input m72_pkg::mem_addr_t a, output int lat);
		@(posedge CLK_32M);
		gfx_addr <= a;
		gfx_req <= ~gfx_req;
		lat = 0;
		do begin
			@(posedge CLK_32M);
			#1;
			lat++;
			if (lat > ACK_LIMIT)
				abort_run("gfx_ack never toggled after a gfx request");
		end while (gfx_ack !== gfx_req);
		check_word(gfx_q, model[a], "gfx read data");
	endtask

	task automatic race_access(input m72_pkg::mem_addr_t ca, input m72_pkg::mem_addr_t ga);
		int n;
		int cpu_at;
		int gfx_at;
		@(posedge CLK_32M);
		cpu_addr <= ca;
		cpu_we <= 1'b0;
		cpu_ds <= 2'b11;
		cpu_req <= ~cpu_req;
		gfx_addr <= ga;
		gfx_req <= ~gfx_req;
		n = 0;
		cpu_at = 0;
		gfx_at = 0;
		while (cpu_at == 0 || gfx_at == 0) begin
			idle_cycles(1);
			n++;
			if (n > ACK_LIMIT)
				abort_run("an ack never came after simultaneous cpu and gfx requests");
			if (cpu_at == 0 && cpu_ack === cpu_req) begin
				cpu_at = n;
				check_word(cpu_q, model[ca], "cpu read under contention");
			end
			if (gfx_at == 0 && gfx_ack === gfx_req) begin
				gfx_at = n;
				check_word(gfx_q, model[ga], "gfx read under contention");
			end
		end
		check_bit(cpu_at < gfx_at, 1'b1, "cpu ack ahead of gfx ack");
	endtask

	initial begin
		int lat;
		m72_pkg::byte_t b;
		m72_pkg::mem_addr_t a;
		m72_pkg::mem_data_t d;
		m72_pkg::be_t ds;
		arst_n <= 1'b0;
		ioctl_downl <= 1'b0;
		ioctl_wr <= 1'b0;
		ioctl_dout <= '0;
		cpu_req <= 1'b0;
		cpu_addr <= '0;
		cpu_we <= 1'b0;
		cpu_ds <= '0;
		cpu_d <= '0;
		gfx_req <= 1'b0;
		gfx_addr <= '0;
		rng_state = 32'h649a;
		n_words = 8 + rand_next() % 9;
		n_bytes = 2 + 2 * n_words + 1;
		// download, hold, reads, writes, isolated, race, streams
		cycle_limit = 40 * (1 + n_bytes + 2 + (n_words + 1) + 2 * WR_TESTS + 4
			+ 3 * STREAM_LEN) + 200;

		repeat (8) @(posedge CLK_32M);
		arst_n <= 1'b1;
		#1;
		check_bit(core_reset_n, 1'b0, "core_reset_n after reset");
		check_bit(rom_loaded, 1'b0, "rom_loaded after reset");
		check_bit(ioctl_wait, 1'b0, "ioctl_wait after reset");
		check_cfg(board_cfg, '0, "board_cfg after reset");
		check_bit(cpu_ack, cpu_req, "cpu_ack after reset");
		check_bit(gfx_ack, gfx_req, "gfx_ack after reset");

		// high byte of the odd trailing word must survive the download
		cpu_access(1'b1, m72_pkg::mem_addr_t'(n_words), 2'b11, rand_next(), lat);
		check_count(lat, ISO_LAT, "isolated cpu write latency");

		@(posedge CLK_32M);
		ioctl_downl <= 1'b1;
		#1;
		for (int i = 0; i < n_bytes; i++) begin
			b = rand_next();
			if (i == 0)
				model_cfg.board_id = b;
			else if (i == 1)
				model_cfg.board_flags = b;
			else if (i % 2 == 0)
				apply_write(m72_pkg::mem_addr_t'((i - 2) / 2), {8'h00, b}, 2'b01);
			else
				apply_write(m72_pkg::mem_addr_t'((i - 2) / 2), {b, 8'h00}, 2'b10);
			send_byte(b);
			// a completed word holds the source off
			check_bit(ioctl_wait, i >= 3 && i % 2 == 1, "ioctl_wait after a download byte");
			idle_cycles(rand_next() % 3);
		end
		@(posedge CLK_32M);
		ioctl_downl <= 1'b0;
		for (int j = 1; j <= m72_pkg::RESET_HOLD; j++) begin
			@(posedge CLK_32M);
			#1;
			check_bit(core_reset_n, j == m72_pkg::RESET_HOLD, "core_reset_n during hold");
		end
		check_bit(rom_loaded, 1'b1, "rom_loaded after download");
		check_bit(ioctl_wait, 1'b0, "ioctl_wait after the download");
		check_cfg(board_cfg, model_cfg, "board_cfg after download");

		for (int k = 0; k <= n_words; k++)
			cpu_access(1'b0, m72_pkg::mem_addr_t'(k), 2'b11, '0, lat);

		for (int k = 0; k < WR_TESTS; k++) begin
			a = m72_pkg::mem_addr_t'(rand_next() % (n_words + 1));
			d = rand_next();
			ds = m72_pkg::be_t'(rand_next());
			cpu_access(1'b1, a, ds, d, lat);
			cpu_access(1'b0, a, 2'b11, '0, lat);
		end

		cpu_access(1'b0, m72_pkg::mem_addr_t'(rand_next() % (n_words + 1)), 2'b11, '0, lat);
		check_count(lat, ISO_LAT, "isolated cpu read latency");
		gfx_access(m72_pkg::mem_addr_t'(rand_next() % (n_words + 1)), lat);
		check_count(lat, ISO_LAT, "isolated gfx read latency");

		race_access(m72_pkg::mem_addr_t'(rand_next() % (n_words + 1)),
			m72_pkg::mem_addr_t'(rand_next() % (n_words + 1)));

		// cpu works in the upper half, gfx reads the loaded words
		fork
			begin
				m72_pkg::mem_addr_t ca;
				int cl;
				for (int k = 0; k < STREAM_LEN; k++) begin
					idle_cycles(rand_next() % 4);
					ca = m72_pkg::mem_addr_t'(12'h800 + rand_next() % 256);
					cpu_access(1'b1, ca, 2'b11, rand_next(), cl);
					cpu_access(1'b0, ca, 2'b11, '0, cl);
				end
			end
			begin
				int gl;
				for (int k = 0; k < STREAM_LEN; k++) begin
					idle_cycles(rand_next() % 4);
					gfx_access(m72_pkg::mem_addr_t'(rand_next() % (n_words + 1)), gl);
				end
			end
		join

		$display("All checks passed");
		$finish;
	end

endmodule

/* m72_mem.f */
source/m72_pkg.sv
source/rom_loader.sv
source/reset_gen.sv
source/mem_arbiter.sv
source/mem_ctrl.sv
source/m72_mem_top.sv
verification/m72_mem_tb.sv

/* Bender.yml */
package:
  name: m72_mem

sources:
  - source/m72_pkg.sv
  - source/rom_loader.sv
  - source/reset_gen.sv
  - source/mem_arbiter.sv
  - source/mem_ctrl.sv
  - source/m72_mem_top.sv
  - target: simulation
    files:
      - verification/m72_mem_tb.sv
